//--- Makefile
SIM      = verilator
VFLAGS   = --binary --timing --assert
TOP      = exec_tb
FILELIST = vlog.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- dv/exec_asserts.sv
//----------------------------
// Concurrent checks on the execute stage outputs, bound into
// every exec_top instance. Reset, hold under stall and flush.
//----------------------------

`timescale 1ns/10ps

module exec_asserts (
    input logic              g_clk,
    input logic              g_resetn,
    input logic              i_flush,
    input logic              o_valid,
    input logic              i_busy,
    input exec_pkg::ex_out_t o_ex_out
);

    // Output register empty once reset is seen
    a_reset_empty: assert property (@(posedge g_clk) !g_resetn |=> !o_valid)
        else $error("o_valid high after reset");

    // Stalled result must not move
    a_hold_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (o_valid && i_busy && !i_flush) |=> (o_valid && $stable(o_ex_out)))
        else $error("o_ex_out changed while stalled");

    a_flush_empty: assert property (@(posedge g_clk) disable iff (!g_resetn)
        i_flush |=> !o_valid)                      // Flush drops result
        else $error("o_valid high after flush");

endmodule

bind exec_top exec_asserts u_asserts (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .i_flush  (i_flush),
    .o_valid  (o_valid),
    .i_busy   (i_busy),
    .o_ex_out (o_ex_out)
);

//--- dv/exec_tb.sv
//----------------------------
// Testbench for the execute stage. Random instructions in three
// phases: no stall, random stall, random stall with flush.
// A reference model feeds a queue that the compare process checks.
//----------------------------

`timescale 1ns/10ps

module exec_tb;

    localparam int CLK_PERIOD = 40;
    localparam int N_PLAIN    = 300;              // No back-pressure
    localparam int N_STALL    = 600;
    localparam int N_FLUSH    = 300;
    localparam int NUM_TESTS  = N_PLAIN + N_STALL + N_FLUSH;

    logic              g_clk;
    logic              g_resetn;
    logic              i_flush;
    logic              i_valid;
    logic              o_busy;
    exec_pkg::ex_in_t  i_ex_in;
    logic              o_valid;
    logic              i_busy;
    exec_pkg::ex_out_t o_ex_out;

    exec_pkg::ex_out_t exp_q[$];                  // Expected results in order
    int                cyc_q[$];                  // Accept cycle per item
    int                cyc;
    int                out_cnt;
    int                flush_cnt;                 // Items dropped by flush
    int                total_sent;
    bit                timing_mode;               // Latency checked
    int unsigned       seed_val;

    exec_top dut0 (.*);

    always #(CLK_PERIOD / 2) g_clk = ~g_clk;

    //----------------------------
    // Reference model
    //----------------------------

    function automatic exec_pkg::ex_out_t ref_exec(input exec_pkg::ex_in_t in);
        exec_pkg::ex_out_t r;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [4:0]        sh;
        logic              slt;
        logic              taken;
        a     = in.opr_a;
        b     = in.opr_b;
        sh    = b[4:0];
        slt   = (a[31] != b[31]) ? a[31] : (a < b); // Sign bits decide first
        taken = 1'b0;
        r     = '0;
        r.trap = in.trap;
        r.rd   = in.rd;
        r.fu   = in.fu;
        r.uop  = in.uop;
        case (in.fu)
            exec_pkg::FU_ALU: begin
                case (in.uop[3:0])
                    exec_pkg::ALU_SUB:  r.opr_a = a - b;
                    exec_pkg::ALU_XOR:  r.opr_a = a ^ b;
                    exec_pkg::ALU_OR:   r.opr_a = a | b;
                    exec_pkg::ALU_AND:  r.opr_a = a & b;
                    exec_pkg::ALU_SLL:  r.opr_a = a << sh;
                    exec_pkg::ALU_SRL:  r.opr_a = a >> sh;
                    exec_pkg::ALU_SRA:  r.opr_a = a[31] ? ~(~a >> sh) : (a >> sh);
                    exec_pkg::ALU_SLT:  r.opr_a = {31'b0, slt};
                    exec_pkg::ALU_SLTU: r.opr_a = {31'b0, a < b};
                    default:            r.opr_a = a + b;
                endcase
            end
            exec_pkg::FU_LSU: begin
                r.opr_a = a + b;                  // Effective address
                r.opr_b = (in.uop == exec_pkg::LSU_STORE) ? in.opr_c : 32'b0;
            end
            exec_pkg::FU_CFU: begin
                r.opr_a = in.opr_c & ~32'b1;      // Branch or jali target
                case (in.uop)
                    exec_pkg::CFU_BEQ:  taken = (a == b);
                    exec_pkg::CFU_BNE:  taken = (a != b);
                    exec_pkg::CFU_BLT:  taken = slt;
                    exec_pkg::CFU_BGE:  taken = !slt;
                    exec_pkg::CFU_BLTU: taken = (a < b);
                    exec_pkg::CFU_BGEU: taken = !(a < b);
                    default:            taken = 1'b0;
                endcase
                if (in.uop == exec_pkg::CFU_JALR) begin
                    r.opr_a = (a + b) & ~32'b1;
                end else if (in.uop != exec_pkg::CFU_JALI) begin
                    r.uop = taken ? exec_pkg::CFU_TAKEN : exec_pkg::CFU_NOT_TAKEN;
                end
            end
            default: begin
                r.opr_a = a;                      // CSR pass-through
                r.opr_b = in.opr_c;
            end
        endcase
        if (in.trap) begin
            r.opr_b = {27'b0, in.rd};             // Trap cause
        end
        return r;
    endfunction

    //----------------------------
    // Stimulus helpers
    //----------------------------

    function automatic logic [31:0] rand_word();
        case ($urandom_range(0, 7))
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            default: return $urandom;
        endcase
    endfunction

    function automatic exec_pkg::ex_in_t rand_instr();
        exec_pkg::ex_in_t t;
        t.trap  = ($urandom_range(0, 15) == 0);
        t.rd    = 5'($urandom);
        t.fu    = exec_pkg::fu_e'(2'($urandom_range(0, 3)));
        t.opr_a = rand_word();
        t.opr_b = rand_word();
        t.opr_c = $urandom;
        if ($urandom_range(0, 3) == 0) begin
            t.opr_b = t.opr_a;                    // Hit the equal cases
        end
        case (t.fu)
            exec_pkg::FU_ALU: t.uop = 5'($urandom_range(0, 9));
            exec_pkg::FU_LSU: t.uop = $urandom_range(0, 1) ? exec_pkg::LSU_STORE
                                                           : exec_pkg::LSU_LOAD;
            exec_pkg::FU_CFU: begin
                case ($urandom_range(0, 7))
                    0:       t.uop = exec_pkg::CFU_BEQ;
                    1:       t.uop = exec_pkg::CFU_BNE;
                    2:       t.uop = exec_pkg::CFU_BLT;
                    3:       t.uop = exec_pkg::CFU_BGE;
                    4:       t.uop = exec_pkg::CFU_BLTU;
                    5:       t.uop = exec_pkg::CFU_BGEU;
                    6:       t.uop = exec_pkg::CFU_JALI;
                    default: t.uop = exec_pkg::CFU_JALR;
                endcase
            end
            default: t.uop = 5'($urandom);        // CSR op is opaque here
        endcase
        return t;
    endfunction

    // Offer count items, holding each until accepted
    task automatic run_phase(input int count, input bit stall, input bit flush_on);
        int sent;
        bit accepted;
        sent = 0;
        while (sent < count) begin
            @(posedge g_clk);
            accepted = i_valid && !o_busy && !i_flush;
            if (accepted) begin
                sent++;
            end
            if (!i_valid || accepted) begin
                if (sent < count && $urandom_range(0, 3) != 0) begin
                    i_valid <= 1'b1;
                    i_ex_in <= rand_instr();
                end else begin
                    i_valid <= 1'b0;              // Idle gap
                end
            end
            i_busy  <= stall && ($urandom_range(0, 2) == 0);
            i_flush <= flush_on && !i_flush && ($urandom_range(0, 15) == 0);
        end
        i_busy     <= 1'b0;
        i_flush    <= 1'b0;
        total_sent += count;
    endtask

    task automatic drain();
        @(negedge g_clk);
        while (exp_q.size() != 0) begin
            @(negedge g_clk);
        end
    endtask

    //----------------------------
    // Checking
    //----------------------------

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("ERROR %0t: %s = %h, expected %h", $time, name, got, want);
            $display("Regression failed");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic compare_out(input exec_pkg::ex_out_t got, input exec_pkg::ex_out_t want);
        check_value("o_ex_out.trap",  32'(got.trap),  32'(want.trap));
        check_value("o_ex_out.rd",    32'(got.rd),    32'(want.rd));
        check_value("o_ex_out.fu",    32'(got.fu),    32'(want.fu));
        check_value("o_ex_out.uop",   32'(got.uop),   32'(want.uop));
        check_value("o_ex_out.opr_a", got.opr_a,      want.opr_a);
        check_value("o_ex_out.opr_b", got.opr_b,      want.opr_b);
    endtask

    // Samples pre-edge values, inputs change by NBA only
    always @(posedge g_clk) begin : compare
        exec_pkg::ex_out_t want;
        int                acc;
        cyc = cyc + 1;
        if (g_resetn) begin
            // Both stages full and the output stalled
            check_value("o_busy", 32'(o_busy), 32'((exp_q.size() == 2) && i_busy));
            if (o_valid && !i_busy) begin
                if (exp_q.size() == 0) begin
                    $display("Regression failed");
                    $fatal(1, "DUT delivered a result with no item in flight");
                end else begin
                    want = exp_q.pop_front();
                    acc  = cyc_q.pop_front();
                    compare_out(o_ex_out, want);
                    if (timing_mode) begin
                        check_value("o_valid latency", cyc - acc, 2); // Visible at N+2
                    end
                    out_cnt++;
                end
            end
            if (i_flush) begin
                flush_cnt += exp_q.size();        // In-flight items dropped
                exp_q.delete();
                cyc_q.delete();
            end
            if (i_valid && !o_busy && !i_flush) begin
                exp_q.push_back(ref_exec(i_ex_in));
                cyc_q.push_back(cyc);
            end
        end
    end

    //----------------------------
    // Main sequence and watchdog
    //----------------------------

    initial begin
        g_clk       = 1'b0;
        g_resetn    = 1'b0;
        i_flush     = 1'b0;
        i_valid     = 1'b0;
        i_busy      = 1'b0;
        i_ex_in     = '0;
        cyc         = 0;
        out_cnt     = 0;
        flush_cnt   = 0;
        total_sent  = 0;
        timing_mode = 1'b1;
        seed_val    = $urandom(17187);
        repeat (16) @(posedge g_clk);
        g_resetn <= 1'b1;
        run_phase(N_PLAIN, 1'b0, 1'b0);
        drain();
        timing_mode = 1'b0;                       // Stalls change latency
        run_phase(N_STALL, 1'b1, 1'b0);
        drain();
        run_phase(N_FLUSH, 1'b1, 1'b1);
        drain();
        if (out_cnt == 0 || out_cnt + flush_cnt != total_sent) begin
            $display("Regression failed");
            $fatal(1, "Item count mismatch: %0d sent, %0d delivered, %0d flushed",
                   total_sent, out_cnt, flush_cnt);
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

    initial begin
        #(NUM_TESTS * 10 * CLK_PERIOD);
        $display("Regression failed");
        $fatal(1, "Watchdog expired before all items were delivered");
    end

endmodule

//--- source/exec_alu.sv
//----------------------------
// Single-cycle integer ALU. Drives the selected result plus the
// raw sum, less-than and equal flags used for addresses and
// branch resolution in the second execute stage.
//----------------------------

`timescale 1ns/10ps

module exec_alu (
    input  exec_pkg::alu_ctl_t          i_ctl,    // Operation select
    input  logic [exec_pkg::XLEN-1:0]   i_lhs,    // Left hand operand
    input  logic [exec_pkg::XLEN-1:0]   i_rhs,    // Right hand operand
    output logic [exec_pkg::XLEN-1:0]   o_result, // Selected result
    output logic [exec_pkg::XLEN-1:0]   o_sum,    // Always lhs + rhs
    output logic                        o_lt,     // lhs < rhs
    output logic                        o_eq      // lhs == rhs
);

    logic [4:0]                shamt;             // Shift amount
    logic                      cmp_unsigned;      // Compare as unsigned
    logic [exec_pkg::XLEN-1:0] diff;              // lhs - rhs

    assign shamt        = i_rhs[4:0];             // Low five bits only
    assign cmp_unsigned = (i_ctl.op == exec_pkg::ALU_SLTU);

    assign o_sum = i_lhs + i_rhs;                 // Address adder
    assign diff  = i_lhs - i_rhs;

    // Flags
    assign o_eq = (i_lhs == i_rhs);
    assign o_lt = cmp_unsigned ? (i_lhs < i_rhs)
                               : ($signed(i_lhs) < $signed(i_rhs));

    //----------------------------
    // Result select
    //----------------------------

    always_comb begin
        case (i_ctl.op)
            exec_pkg::ALU_ADD: begin
                o_result = o_sum;
            end
            exec_pkg::ALU_SUB: begin
                o_result = diff;
            end
            exec_pkg::ALU_XOR: begin
                o_result = i_lhs ^ i_rhs;
            end
            exec_pkg::ALU_OR: begin
                o_result = i_lhs | i_rhs;
            end
            exec_pkg::ALU_AND: begin
                o_result = i_lhs & i_rhs;
            end
            exec_pkg::ALU_SLL: begin
                o_result = i_lhs << shamt;        // Logical left
            end
            exec_pkg::ALU_SRL: begin
                o_result = i_lhs >> shamt;        // Zero fill
            end
            exec_pkg::ALU_SRA: begin
                o_result = $signed(i_lhs) >>> shamt; // Sign fill
            end
            exec_pkg::ALU_SLT, exec_pkg::ALU_SLTU: begin
                // Signedness already folded into o_lt
                o_result = {{(exec_pkg::XLEN-1){1'b0}}, o_lt};
            end
            default: begin
                o_result = o_sum;                 // Unused encodings
            end
        endcase
    end

endmodule

//--- source/exec_decode.sv
//----------------------------
// First execute stage. Registers the incoming instruction and
// turns unit plus micro-op into ALU control for stage two.
// Holds one item under the valid/busy level handshake.
//----------------------------

`timescale 1ns/10ps

module exec_decode (
    input  logic              g_clk,      // Global clock
    input  logic              g_resetn,   // Synchronous reset, active low
    input  logic              i_flush,    // Drop the held item
    input  logic              i_valid,    // Upstream item present
    output logic              o_busy,     // Cannot take an item this cycle
    input  exec_pkg::ex_in_t  i_ex_in,    // Upstream instruction
    output logic              o_valid,    // Held item present
    input  logic              i_busy,     // Stage two is stalled
    output exec_pkg::ex_mid_t o_mid       // Held item plus ALU control
);

    exec_pkg::alu_ctl_t  n_ctl;           // Decoded ALU control
    exec_pkg::ex_mid_t   n_mid;           // Next register contents
    logic                accept;          // Transfer on this edge

    //----------------------------
    // ALU control decode
    //----------------------------

    always_comb begin
        n_ctl.op     = exec_pkg::ALU_ADD;  // Address / pass-through default
        n_ctl.is_cmp = 1'b0;
        case (i_ex_in.fu)
            exec_pkg::FU_ALU: begin
                // ALU uop is the opcode zero-extended
                n_ctl.op = exec_pkg::alu_op_e'(i_ex_in.uop[3:0]);
            end
            exec_pkg::FU_CFU: begin
                case (exec_pkg::cfu_op_e'(i_ex_in.uop))
                    exec_pkg::CFU_BEQ, exec_pkg::CFU_BNE,
                    exec_pkg::CFU_BLT, exec_pkg::CFU_BGE: begin
                        n_ctl.op     = exec_pkg::ALU_SLT;  // Signed compare
                        n_ctl.is_cmp = 1'b1;
                    end
                    exec_pkg::CFU_BLTU, exec_pkg::CFU_BGEU: begin
                        n_ctl.op     = exec_pkg::ALU_SLTU; // Unsigned compare
                        n_ctl.is_cmp = 1'b1;
                    end
                    default: begin
                        n_ctl.op = exec_pkg::ALU_ADD;      // jalr target sum
                    end
                endcase
            end
            default: begin
                n_ctl.op = exec_pkg::ALU_ADD;              // LSU and CSR
            end
        endcase
    end

    // Pack the next stage register
    always_comb begin
        n_mid.trap  = i_ex_in.trap;
        n_mid.rd    = i_ex_in.rd;
        n_mid.fu    = i_ex_in.fu;
        n_mid.uop   = i_ex_in.uop;
        n_mid.opr_a = i_ex_in.opr_a;
        n_mid.opr_b = i_ex_in.opr_b;
        n_mid.opr_c = i_ex_in.opr_c;
        n_mid.ctl   = n_ctl;
    end

    //----------------------------
    // Handshake and register
    //----------------------------

    assign o_busy = o_valid && i_busy;     // Full and cannot drain
    assign accept = i_valid && !o_busy && !i_flush;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_valid <= 1'b0;               // Empty the stage
        end else if (!o_busy) begin
            o_valid <= i_valid;            // Drained or refilled
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            o_mid <= n_mid;                // Payload only, no reset
        end
    end

endmodule

//--- source/exec_pkg.sv
//----------------------------
// Shared types for the two-stage execute block. Widths, unit and
// micro-op enums, and the packed structs passed between stages.
// Referenced by scoped name from every module and the testbench.
//----------------------------

package exec_pkg;

    parameter int XLEN = 32;                 // Data path width

    //----------------------------
    // Unit and micro-op encodings
    //----------------------------

    typedef enum logic [1:0] {
        FU_ALU = 2'd0,                       // Integer ALU
        FU_LSU = 2'd1,                       // Load/store address gen
        FU_CFU = 2'd2,                       // Branches and jumps
        FU_CSR = 2'd3                        // CSR access
    } fu_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_XOR  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_AND  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,                     // Signed set-less-than
        ALU_SLTU = 4'd9                      // Unsigned set-less-than
    } alu_op_e;

    // Top two bits group the CFU ops: 00 conditional, 01 resolved, 10 jump
    typedef enum logic [4:0] {
        CFU_BEQ       = 5'b00_001,
        CFU_BGE       = 5'b00_010,
        CFU_BGEU      = 5'b00_011,
        CFU_BLT       = 5'b00_100,
        CFU_BLTU      = 5'b00_101,
        CFU_BNE       = 5'b00_110,
        CFU_NOT_TAKEN = 5'b01_000,           // Branch resolved, fall through
        CFU_TAKEN     = 5'b01_001,           // Branch resolved, taken
        CFU_JALI      = 5'b10_010,           // Jump, target in opr_c
        CFU_JALR      = 5'b10_100            // Jump, target is rs1 + imm
    } cfu_op_e;

    typedef enum logic [4:0] {
        LSU_LOAD  = 5'b01_000,
        LSU_STORE = 5'b10_000
    } lsu_op_e;

    typedef logic [4:0] uop_t;               // Meaning set by the fu field

    //----------------------------
    // Stage payloads
    //----------------------------

    typedef struct packed {
        logic            trap;               // Raise a trap, cause in rd
        logic [4:0]      rd;                 // Destination register
        fu_e             fu;                 // Functional unit
        uop_t            uop;                // Micro-op code
        logic [XLEN-1:0] opr_a;              // Operand A
        logic [XLEN-1:0] opr_b;              // Operand B
        logic [XLEN-1:0] opr_c;              // Operand C
    } ex_in_t;

    typedef struct packed {
        alu_op_e op;                         // ALU operation
        logic    is_cmp;                     // Conditional branch compare
    } alu_ctl_t;

    typedef struct packed {
        logic            trap;
        logic [4:0]      rd;
        fu_e             fu;
        uop_t            uop;
        logic [XLEN-1:0] opr_a;
        logic [XLEN-1:0] opr_b;
        logic [XLEN-1:0] opr_c;
        alu_ctl_t        ctl;                // Decoded in stage one
    } ex_mid_t;

    typedef struct packed {
        logic            trap;
        logic [4:0]      rd;
        fu_e             fu;
        uop_t            uop;                // Rewritten for branches
        logic [XLEN-1:0] opr_a;              // Result / address / target
        logic [XLEN-1:0] opr_b;              // Store data / CSR data / cause
    } ex_out_t;

endpackage

//--- source/exec_resolve.sv
//----------------------------
// Second execute stage. Runs the ALU, resolves conditional
// branches, forms operands A and B per unit and registers the
// result towards the memory stage.
//----------------------------

`timescale 1ns/10ps

module exec_resolve (
    input  logic              g_clk,      // Global clock
    input  logic              g_resetn,   // Synchronous reset, active low
    input  logic              i_flush,    // Drop the held item
    input  logic              i_valid,    // Stage one item present
    output logic              o_busy,     // Cannot take an item this cycle
    input  exec_pkg::ex_mid_t i_mid,      // Stage one item
    output logic              o_valid,    // Result present
    input  logic              i_busy,     // Downstream stalled
    output exec_pkg::ex_out_t o_ex_out    // Registered result
);

    logic [exec_pkg::XLEN-1:0] alu_result; // Selected ALU result
    logic [exec_pkg::XLEN-1:0] alu_sum;    // opr_a + opr_b
    logic                      alu_lt;
    logic                      alu_eq;
    logic                      is_cond;    // Conditional branch
    logic                      cond_taken; // Branch condition holds
    logic                      is_store;
    logic                      is_jalr;
    exec_pkg::ex_out_t         n_out;      // Next output register
    logic                      accept;

    exec_alu u_alu (
        .i_ctl    (i_mid.ctl),
        .i_lhs    (i_mid.opr_a),
        .i_rhs    (i_mid.opr_b),
        .o_result (alu_result),
        .o_sum    (alu_sum),
        .o_lt     (alu_lt),
        .o_eq     (alu_eq)
    );

    //----------------------------
    // Branch resolution
    //----------------------------

    assign is_cond  = (i_mid.fu == exec_pkg::FU_CFU) && i_mid.ctl.is_cmp;
    assign is_jalr  = (i_mid.uop == exec_pkg::CFU_JALR);
    assign is_store = (i_mid.uop == exec_pkg::LSU_STORE);

    always_comb begin
        case (exec_pkg::cfu_op_e'(i_mid.uop))
            exec_pkg::CFU_BEQ:  cond_taken =  alu_eq;
            exec_pkg::CFU_BNE:  cond_taken = !alu_eq;
            exec_pkg::CFU_BLT:  cond_taken =  alu_lt;  // Signed lt
            exec_pkg::CFU_BGE:  cond_taken = !alu_lt;
            exec_pkg::CFU_BLTU: cond_taken =  alu_lt;  // Unsigned lt
            exec_pkg::CFU_BGEU: cond_taken = !alu_lt;
            default:            cond_taken = 1'b0;
        endcase
    end

    //----------------------------
    // Operand formation
    //----------------------------

    always_comb begin
        n_out.trap  = i_mid.trap;
        n_out.rd    = i_mid.rd;
        n_out.fu    = i_mid.fu;
        n_out.uop   = i_mid.uop;
        n_out.opr_b = '0;
        case (i_mid.fu)
            exec_pkg::FU_ALU: begin
                n_out.opr_a = alu_result;
            end
            exec_pkg::FU_LSU: begin
                n_out.opr_a = alu_sum;                     // Effective address
                if (is_store) begin
                    n_out.opr_b = i_mid.opr_c;             // Store data
                end
            end
            exec_pkg::FU_CFU: begin
                if (is_jalr) begin
                    n_out.opr_a = {alu_sum[exec_pkg::XLEN-1:1], 1'b0};
                end else begin
                    n_out.opr_a = {i_mid.opr_c[exec_pkg::XLEN-1:1], 1'b0};
                end
                if (is_cond) begin
                    n_out.uop = cond_taken ? exec_pkg::CFU_TAKEN
                                           : exec_pkg::CFU_NOT_TAKEN;
                end
            end
            default: begin
                n_out.opr_a = i_mid.opr_a;                 // CSR write data
                n_out.opr_b = i_mid.opr_c;                 // CSR address
            end
        endcase
        if (i_mid.trap) begin
            n_out.opr_b = {{(exec_pkg::XLEN-5){1'b0}}, i_mid.rd}; // Cause
        end
    end

    //----------------------------
    // Handshake and register
    //----------------------------

    assign o_busy = o_valid && i_busy;
    assign accept = i_valid && !o_busy && !i_flush;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || i_flush) begin
            o_valid <= 1'b0;
        end else if (!o_busy) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            o_ex_out <= n_out;             // Holds while downstream busy
        end
    end

endmodule

//--- source/exec_top.sv
//----------------------------
// Execute stage top level. Chains the decode and resolve
// register stages, two items in flight at most.
//----------------------------

`timescale 1ns/10ps

module exec_top (
    input  logic              g_clk,      // Global clock
    input  logic              g_resetn,   // Synchronous reset, active low
    input  logic              i_flush,    // Empty both stages
    input  logic              i_valid,    // Instruction present
    output logic              o_busy,     // Stage cannot accept
    input  exec_pkg::ex_in_t  i_ex_in,    // Decoded instruction
    output logic              o_valid,    // Result present
    input  logic              i_busy,     // Downstream stalled
    output exec_pkg::ex_out_t o_ex_out    // Execute result
);

    logic              mid_valid;         // Stage one holds an item
    logic              mid_busy;          // Stage two stalled
    exec_pkg::ex_mid_t mid;               // Stage one register

    exec_decode u_decode (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_flush  (i_flush),
        .i_valid  (i_valid),
        .o_busy   (o_busy),
        .i_ex_in  (i_ex_in),
        .o_valid  (mid_valid),
        .i_busy   (mid_busy),
        .o_mid    (mid)
    );

    exec_resolve u_resolve (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .i_flush  (i_flush),
        .i_valid  (mid_valid),
        .o_busy   (mid_busy),
        .i_mid    (mid),
        .o_valid  (o_valid),
        .i_busy   (i_busy),
        .o_ex_out (o_ex_out)
    );

endmodule

//--- vlog.f
source/exec_pkg.sv
source/exec_alu.sv
source/exec_decode.sv
source/exec_resolve.sv
source/exec_top.sv
dv/exec_asserts.sv
dv/exec_tb.sv
